// ==== gpu_config.svh ====
`ifndef GPU_CONFIG_SVH
`define GPU_CONFIG_SVH

// screen size in pixels
`define WIDTH 320
`define HEIGHT 240

// coordinate widths, wide enough for the screen size above
`define WIDTH_BITS 9
`define HEIGHT_BITS 8

// one colour channel, three of them per pixel
`define CHANNEL_BITS 8

`endif

// ==== gpuPixelPkg.sv ====
`include "gpu_config.svh"

package gpuPixelPkg;

  // 24-bit rgb colour
  typedef struct packed
  {
    logic [`CHANNEL_BITS-1:0] red;
    logic [`CHANNEL_BITS-1:0] green;
    logic [`CHANNEL_BITS-1:0] blue;
  } colorT;

  // one pixel of an engine stream, 42 bits
  typedef struct packed
  {
    logic                    valid;
    logic [`WIDTH_BITS-1:0]  x;
    logic [`HEIGHT_BITS-1:0] y;
    colorT                   color;
  } pixelT;

endpackage

// ==== gpuCmdPkg.sv ====
`include "gpu_config.svh"

package gpuCmdPkg;

  // shape opcode of a draw command
  typedef enum logic [1:0]
  {
    SHAPE_NONE   = 2'd0,
    SHAPE_CIRCLE = 2'd1,
    SHAPE_RECT   = 2'd2
  } shapeT;

  // one draw command, 60 bits
  // sizeA is the radius of a circle or the width of a rectangle
  // sizeB is the rectangle height, ignored for circles
  typedef struct packed
  {
    shapeT                   shape;
    logic [`WIDTH_BITS-1:0]  anchorX;
    logic [`HEIGHT_BITS-1:0] anchorY;
    logic [`WIDTH_BITS-1:0]  sizeA;
    logic [`HEIGHT_BITS-1:0] sizeB;
    gpuPixelPkg::colorT      color;
  } drawCmdT;

endpackage

// ==== riseEdgeDetect.sv ====
`timescale 1ns/1ps
`include "gpu_config.svh"

module riseEdgeDetect
(
  input  logic clk,
  input  logic n_rst,
  input  logic data_i,
  output logic risingEdge_o
);

  logic dataPrev;

  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
      dataPrev <= 1'b0;
    else
      dataPrev <= data_i;
  end

  // one cycle high on a low to high transition
  assign risingEdge_o = data_i && !dataPrev;

endmodule

// ==== filledCircle.sv ====
`timescale 1ns/1ps
`include "gpu_config.svh"

module filledCircle
(
  input  logic                    clk,
  input  logic                    n_rst,
  input  logic                    start_i,
  input  logic [`WIDTH_BITS-1:0]  centerX_i,
  input  logic [`HEIGHT_BITS-1:0] centerY_i,
  input  logic [`WIDTH_BITS-1:0]  radius_i,
  input  gpuPixelPkg::colorT      color_i,
  output gpuPixelPkg::pixelT      pixel_o,
  output logic                    busy_o,
  output logic                    done_o
);

  // headroom so the decision variable cannot overflow
  localparam int DEC_BITS = `WIDTH_BITS + 3;

  typedef enum logic [1:0]
  {
    IDLE,
    LOAD,
    SWEEP
  } phaseT;

  phaseT phase;
  logic [1:0] chordIdx;
  logic doneReg;
  logic startEdge;

  // midpoint recurrence, dec is two's complement
  logic [DEC_BITS-1:0] dec;
  logic [`WIDTH_BITS-1:0] offX;
  logic [`WIDTH_BITS-1:0] offY;
  logic [DEC_BITS-1:0] offXExt;
  logic [DEC_BITS-1:0] offYExt;

  // chord endpoints and sweep position
  logic [`WIDTH_BITS-1:0] halfSpan;
  logic [`HEIGHT_BITS-1:0] chordY;
  logic [`WIDTH_BITS-1:0] chordLeft;
  logic [`WIDTH_BITS-1:0] chordRight;
  logic [`WIDTH_BITS-1:0] curX;
  logic [`WIDTH_BITS-1:0] endX;
  logic [`HEIGHT_BITS-1:0] curY;

  logic chordEnd;
  logic setEnd;
  logic lastSet;

  riseEdgeDetect uStartEdge
  (
    .clk          (clk),
    .n_rst        (n_rst),
    .data_i       (start_i),
    .risingEdge_o (startEdge)
  );

  assign offXExt = {3'b000, offX};
  assign offYExt = {3'b000, offY};

  // four chords per step, top pair first then bottom pair
  always_comb
  begin
    case (chordIdx)
      2'd0:
      begin
        halfSpan = offX;
        chordY   = centerY_i + offY[`HEIGHT_BITS-1:0];
      end
      2'd1:
      begin
        halfSpan = offY;
        chordY   = centerY_i + offX[`HEIGHT_BITS-1:0];
      end
      2'd2:
      begin
        halfSpan = offY;
        chordY   = centerY_i - offX[`HEIGHT_BITS-1:0];
      end
      default:
      begin
        halfSpan = offX;
        chordY   = centerY_i - offY[`HEIGHT_BITS-1:0];
      end
    endcase
  end

  assign chordLeft  = centerX_i - halfSpan;
  assign chordRight = centerX_i + halfSpan;

  assign chordEnd = (phase == SWEEP) && (curX == endX);
  assign setEnd   = chordEnd && (chordIdx == 2'd3);
  assign lastSet  = (offX >= offY);

  // chord sequencing, one LOAD stall ahead of every chord
  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
    begin
      phase    <= IDLE;
      chordIdx <= 2'd0;
      doneReg  <= 1'b0;
    end
    else
    begin
      doneReg <= 1'b0;
      if (startEdge)
      begin
        phase    <= LOAD;
        chordIdx <= 2'd0;
      end
      else if (start_i)
      begin
        case (phase)
          LOAD:
            phase <= SWEEP;
          SWEEP:
            if (chordEnd)
            begin
              // wraps to the first chord after the fourth
              chordIdx <= chordIdx + 2'd1;
              if (setEnd && lastSet)
              begin
                phase   <= IDLE;
                doneReg <= 1'b1;
              end
              else
                phase <= LOAD;
            end
          default:
            phase <= IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (startEdge)
    begin
      dec  <= DEC_BITS'(1) - {3'b000, radius_i};
      offX <= '0;
      offY <= radius_i;
    end
    else if (start_i && setEnd && !lastSet)
    begin
      // negative dec keeps y, otherwise step y inwards
      if (dec[DEC_BITS-1])
        dec <= dec + (offXExt << 1) + DEC_BITS'(3);
      else
      begin
        dec  <= dec + ((offXExt - offYExt) << 1) + DEC_BITS'(5);
        offY <= offY - 1'b1;
      end
      offX <= offX + 1'b1;
    end

    if (start_i && (phase == LOAD))
    begin
      curX <= chordLeft;
      endX <= chordRight;
      curY <= chordY;
    end
    else if (start_i && (phase == SWEEP) && !chordEnd)
      curX <= curX + 1'b1;
  end

  assign pixel_o.valid = (phase == SWEEP);
  assign pixel_o.x     = curX;
  assign pixel_o.y     = curY;
  assign pixel_o.color = color_i;

  assign busy_o = (phase != IDLE);
  assign done_o = doneReg;

endmodule

// ==== filledRect.sv ====
`timescale 1ns/1ps
`include "gpu_config.svh"

module filledRect
(
  input  logic                    clk,
  input  logic                    n_rst,
  input  logic                    start_i,
  input  logic [`WIDTH_BITS-1:0]  originX_i,
  input  logic [`HEIGHT_BITS-1:0] originY_i,
  input  logic [`WIDTH_BITS-1:0]  width_i,
  input  logic [`HEIGHT_BITS-1:0] height_i,
  input  gpuPixelPkg::colorT      color_i,
  output gpuPixelPkg::pixelT      pixel_o,
  output logic                    busy_o,
  output logic                    done_o
);

  logic active;
  logic doneReg;
  logic startEdge;

  logic [`WIDTH_BITS-1:0] curX;
  logic [`HEIGHT_BITS-1:0] curY;
  // pixels left in the row and rows left after this one
  logic [`WIDTH_BITS-1:0] colLeft;
  logic [`HEIGHT_BITS-1:0] rowLeft;

  logic emptyRect;
  logic rowEnd;
  logic lastPixel;

  riseEdgeDetect uStartEdge
  (
    .clk          (clk),
    .n_rst        (n_rst),
    .data_i       (start_i),
    .risingEdge_o (startEdge)
  );

  assign emptyRect = (width_i == '0) || (height_i == '0);
  assign rowEnd    = (colLeft == '0);
  assign lastPixel = active && rowEnd && (rowLeft == '0);

  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
    begin
      active  <= 1'b0;
      doneReg <= 1'b0;
    end
    else
    begin
      doneReg <= 1'b0;
      if (startEdge)
      begin
        active  <= !emptyRect;
        // nothing to draw, finish at once
        doneReg <= emptyRect;
      end
      else if (lastPixel)
      begin
        active  <= 1'b0;
        doneReg <= 1'b1;
      end
    end
  end

  // row scan, one pixel per cycle
  always_ff @(posedge clk)
  begin
    if (startEdge)
    begin
      curX    <= originX_i;
      curY    <= originY_i;
      colLeft <= width_i - 1'b1;
      rowLeft <= height_i - 1'b1;
    end
    else if (active)
    begin
      if (rowEnd)
      begin
        curX    <= originX_i;
        curY    <= curY + 1'b1;
        colLeft <= width_i - 1'b1;
        rowLeft <= rowLeft - 1'b1;
      end
      else
      begin
        curX    <= curX + 1'b1;
        colLeft <= colLeft - 1'b1;
      end
    end
  end

  assign pixel_o.valid = active;
  assign pixel_o.x     = curX;
  assign pixel_o.y     = curY;
  assign pixel_o.color = color_i;

  assign busy_o = active;
  assign done_o = doneReg;

endmodule

// ==== gpuCmdDispatch.sv ====
`timescale 1ns/1ps
`include "gpu_config.svh"

module gpuCmdDispatch
(
  input  logic                 clk,
  input  logic                 n_rst,
  input  logic                 cmdValid_i,
  input  gpuCmdPkg::drawCmdT   cmd_i,
  output gpuCmdPkg::drawCmdT   latchedCmd_o,
  output logic                 circleStart_o,
  output logic                 rectStart_o,
  input  gpuPixelPkg::pixelT   circlePixel_i,
  input  gpuPixelPkg::pixelT   rectPixel_i,
  input  logic                 circleDone_i,
  input  logic                 rectDone_i,
  output gpuPixelPkg::pixelT   selPixel_o,
  output logic                 busy_o,
  output logic                 done_o
);

  import gpuCmdPkg::*;

  typedef enum logic
  {
    IDLE,
    ACTIVE
  } stateT;

  stateT state;
  drawCmdT cmdReg;
  logic doneReg;
  logic accept;
  logic engineDone;

  // commands arriving while busy are dropped
  assign accept = (state == IDLE) && cmdValid_i;

  always_comb
  begin
    case (cmdReg.shape)
      SHAPE_CIRCLE: engineDone = circleDone_i;
      SHAPE_RECT:   engineDone = rectDone_i;
      default:      engineDone = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
    begin
      state   <= IDLE;
      doneReg <= 1'b0;
    end
    else
    begin
      doneReg <= (state == ACTIVE) && engineDone;
      if (accept)
        state <= ACTIVE;
      else if ((state == ACTIVE) && engineDone)
        state <= IDLE;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmdReg <= cmd_i;
  end

  // start levels held until the engine reports done
  assign circleStart_o = (state == ACTIVE) && (cmdReg.shape == SHAPE_CIRCLE);
  assign rectStart_o   = (state == ACTIVE) && (cmdReg.shape == SHAPE_RECT);

  always_comb
  begin
    selPixel_o = '0;
    if (circleStart_o)
      selPixel_o = circlePixel_i;
    else if (rectStart_o)
      selPixel_o = rectPixel_i;
  end

  assign latchedCmd_o = cmdReg;
  assign busy_o       = (state == ACTIVE);
  assign done_o       = doneReg;

endmodule

// ==== pixelClip.sv ====
`timescale 1ns/1ps
`include "gpu_config.svh"

module pixelClip
(
  input  logic               clk,
  input  logic               n_rst,
  input  gpuPixelPkg::pixelT pixel_i,
  output logic               fbWrite_o,
  output gpuPixelPkg::pixelT fbPixel_o
);

  import gpuPixelPkg::*;

  logic writeReg;
  logic onScreen;
  logic [`WIDTH_BITS-1:0] xReg;
  logic [`HEIGHT_BITS-1:0] yReg;
  colorT colorReg;

  // negative coordinates wrap to large values and fail here too
  assign onScreen = (pixel_i.x < `WIDTH_BITS'(`WIDTH)) &&
                    (pixel_i.y < `HEIGHT_BITS'(`HEIGHT));

  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
      writeReg <= 1'b0;
    else
      writeReg <= pixel_i.valid && onScreen;
  end

  always_ff @(posedge clk)
  begin
    xReg     <= pixel_i.x;
    yReg     <= pixel_i.y;
    colorReg <= pixel_i.color;
  end

  assign fbWrite_o       = writeReg;
  assign fbPixel_o.valid = writeReg;
  assign fbPixel_o.x     = xReg;
  assign fbPixel_o.y     = yReg;
  assign fbPixel_o.color = colorReg;

endmodule

// ==== gpuTop.sv ====
`timescale 1ns/1ps
`include "gpu_config.svh"

module gpuTop
(
  input  logic               clk,
  input  logic               n_rst,
  input  logic               cmdValid_i,
  input  gpuCmdPkg::drawCmdT cmd_i,
  output logic               busy_o,
  output logic               done_o,
  output logic               fbWrite_o,
  output gpuPixelPkg::pixelT fbPixel_o
);

  import gpuPixelPkg::*;
  import gpuCmdPkg::*;

  drawCmdT latchedCmd;
  logic circleStart;
  logic rectStart;
  pixelT circlePixel;
  pixelT rectPixel;
  logic circleDone;
  logic rectDone;
  pixelT selPixel;

  gpuCmdDispatch uDispatch
  (
    .clk           (clk),
    .n_rst         (n_rst),
    .cmdValid_i    (cmdValid_i),
    .cmd_i         (cmd_i),
    .latchedCmd_o  (latchedCmd),
    .circleStart_o (circleStart),
    .rectStart_o   (rectStart),
    .circlePixel_i (circlePixel),
    .rectPixel_i   (rectPixel),
    .circleDone_i  (circleDone),
    .rectDone_i    (rectDone),
    .selPixel_o    (selPixel),
    .busy_o        (busy_o),
    .done_o        (done_o)
  );

  // engine busy levels stay local, the dispatcher tracks activity
  filledCircle uCircle
  (
    .clk       (clk),
    .n_rst     (n_rst),
    .start_i   (circleStart),
    .centerX_i (latchedCmd.anchorX),
    .centerY_i (latchedCmd.anchorY),
    .radius_i  (latchedCmd.sizeA),
    .color_i   (latchedCmd.color),
    .pixel_o   (circlePixel),
    .busy_o    (),
    .done_o    (circleDone)
  );

  filledRect uRect
  (
    .clk       (clk),
    .n_rst     (n_rst),
    .start_i   (rectStart),
    .originX_i (latchedCmd.anchorX),
    .originY_i (latchedCmd.anchorY),
    .width_i   (latchedCmd.sizeA),
    .height_i  (latchedCmd.sizeB),
    .color_i   (latchedCmd.color),
    .pixel_o   (rectPixel),
    .busy_o    (),
    .done_o    (rectDone)
  );

  pixelClip uClip
  (
    .clk       (clk),
    .n_rst     (n_rst),
    .pixel_i   (selPixel),
    .fbWrite_o (fbWrite_o),
    .fbPixel_o (fbPixel_o)
  );

endmodule

// ==== tb_gpuTop.sv ====
`timescale 1ns/1ps
`include "gpu_config.svh"

module tb_gpuTop;

  import gpuPixelPkg::*;
  import gpuCmdPkg::*;

  localparam int NUM_CMDS = 14;
  localparam int FIELDS = 10;
  localparam int CLK_PERIOD = 4;
  localparam int RESET_CYCLES = 16;
  localparam int MARGIN_CYCLES = 2000;

  logic clk;
  logic n_rst;
  logic cmdValid;
  drawCmdT cmd;
  logic busy;
  logic done;
  logic fbWrite;
  pixelT fbPixel;

  // ten words per command as listed in the header of gpu_input.txt
  logic [31:0] stim [0:NUM_CMDS*FIELDS-1];

  int errors;
  int doneCount;
  int budgetCycles;
  logic budgetReady;
  int seedVal;

  // expectations of the command in flight
  logic inFlight;
  logic busyExpected;
  colorT expColor;
  logic isCircle;
  int centerX;
  int centerY;
  int radius;
  int expCount;
  int expSumX;
  int expSumY;

  // writes seen since the last done
  int gotCount;
  int gotSumX;
  int gotSumY;

  gpuTop u_dut
  (
    .clk        (clk),
    .n_rst      (n_rst),
    .cmdValid_i (cmdValid),
    .cmd_i      (cmd),
    .busy_o     (busy),
    .done_o     (done),
    .fbWrite_o  (fbWrite),
    .fbPixel_o  (fbPixel)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic checkValue(input string what, input int got, input int expected);
    if (got != expected)
    begin
      errors++;
      $display("Error at %0t ns: %s, got %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  // upper bound of engine cycles for one command
  function automatic int commandBound(input int idx);
    int a;
    int b;
    int area;
    a = stim[idx*FIELDS+3];
    b = stim[idx*FIELDS+4];
    // circles revisit pixels and stall between chords
    if (stim[idx*FIELDS] == 1)
      area = 2 * (2*a + 1) * (2*a + 1);
    else
      area = a * b;
    return area + 40;
  endfunction

  task automatic runCommand(input int idx);
    int base;
    int gap;
    drawCmdT next;
    drawCmdT junk;
    base = idx * FIELDS;
    gap = $urandom % 8;
    next.shape   = shapeT'(stim[base][1:0]);
    next.anchorX = stim[base+1][`WIDTH_BITS-1:0];
    next.anchorY = stim[base+2][`HEIGHT_BITS-1:0];
    next.sizeA   = stim[base+3][`WIDTH_BITS-1:0];
    next.sizeB   = stim[base+4][`HEIGHT_BITS-1:0];
    next.color   = stim[base+5][23:0];
    // a big rectangle in another colour that shows up if it slips in
    junk.shape   = SHAPE_RECT;
    junk.anchorX = '0;
    junk.anchorY = '0;
    junk.sizeA   = 9'd40;
    junk.sizeB   = 8'd40;
    junk.color   = 24'h777777;
    repeat (gap) @(negedge clk);
    @(negedge clk);
    expColor = next.color;
    isCircle = (next.shape == SHAPE_CIRCLE);
    centerX  = stim[base+1];
    centerY  = stim[base+2];
    radius   = stim[base+3];
    expCount = stim[base+7];
    expSumX  = stim[base+8];
    expSumY  = stim[base+9];
    cmd = next;
    cmdValid = 1'b1;
    inFlight = 1'b1;
    @(negedge clk);
    cmdValid = 1'b0;
    busyExpected = 1'b1;
    if (stim[base+6] != 0)
    begin
      // strobe while busy that must be dropped
      @(negedge clk);
      cmd = junk;
      cmdValid = 1'b1;
      @(negedge clk);
      cmdValid = 1'b0;
    end
    wait (doneCount == idx + 1);
  endtask

  // write monitor sampling the registered outputs at the rising edge
  always @(posedge clk)
  begin : writeMonitor
    int dx;
    int dy;
    if (fbWrite)
    begin
      checkValue("write with no command in flight", inFlight, 1);
      checkValue("pixel valid flag of a write", fbPixel.valid, 1);
      checkValue("write x below WIDTH", fbPixel.x < `WIDTH, 1);
      checkValue("write y below HEIGHT", fbPixel.y < `HEIGHT, 1);
      checkValue("write colour", fbPixel.color, expColor);
      if (isCircle)
      begin
        dx = int'(fbPixel.x) - centerX;
        dy = int'(fbPixel.y) - centerY;
        // midpoint rounding reaches up to r*r + r
        checkValue("write within circle radius",
                   (dx*dx + dy*dy) <= (radius*radius + radius), 1);
      end
      gotCount++;
      gotSumX += fbPixel.x;
      gotSumY += fbPixel.y;
    end
    else
      checkValue("pixel valid flag without a write", fbPixel.valid, 0);
    if (done)
    begin
      checkValue("done with no command in flight", inFlight, 1);
      checkValue("busy in the done cycle", busy, 0);
      checkValue("write count", gotCount, expCount);
      checkValue("sum of x", gotSumX, expSumX);
      checkValue("sum of y", gotSumY, expSumY);
      gotCount = 0;
      gotSumX = 0;
      gotSumY = 0;
      inFlight = 1'b0;
      busyExpected = 1'b0;
      doneCount++;
    end
    else if (busyExpected)
      checkValue("busy between acceptance and done", busy, 1);
    else if (!inFlight)
      checkValue("busy while idle", busy, 0);
  end

  initial
  begin
    errors = 0;
    doneCount = 0;
    budgetReady = 1'b0;
    budgetCycles = 0;
    inFlight = 1'b0;
    busyExpected = 1'b0;
    expColor = '0;
    isCircle = 1'b0;
    centerX = 0;
    centerY = 0;
    radius = 0;
    expCount = 0;
    expSumX = 0;
    expSumY = 0;
    gotCount = 0;
    gotSumX = 0;
    gotSumY = 0;
    n_rst = 1'b0;
    cmdValid = 1'b0;
    cmd = '0;
    seedVal = $urandom(41);
    $readmemh("gpu_input.txt", stim);
    budgetCycles = RESET_CYCLES + MARGIN_CYCLES;
    if (!$isunknown(stim[NUM_CMDS*FIELDS-1]))
    begin
      for (int i = 0; i < NUM_CMDS; i++)
        budgetCycles += commandBound(i);
    end
    budgetReady = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    n_rst = 1'b1;
    // a few idle cycles with all outputs low
    repeat (4) @(negedge clk);
    if ($isunknown(stim[NUM_CMDS*FIELDS-1]))
    begin
      errors++;
      $display("Stimulus file gpu_input.txt is missing or has too few entries");
    end
    else
    begin
      for (int i = 0; i < NUM_CMDS; i++)
        runCommand(i);
    end
    repeat (4) @(negedge clk);
    $display("Run finished: %0d commands done, %0d errors", doneCount, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  // watchdog armed once the stimulus is read
  initial
  begin
    wait (budgetReady);
    repeat (budgetCycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", budgetCycles);
    $display("Run finished: %0d commands done, %0d errors", doneCount, errors);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== gpu_input.txt ====
// columns, all hex: shape x y sizeA sizeB colour pokeWhileBusy count sumX sumY
// shape 0 none, 1 circle (sizeA radius), 2 rect (sizeA width, sizeB height)

// rectangles on screen
2 00A 014 004 003 FF0000 0 00C 08A 0FC
2 064 032 010 008 00FF00 0 080 35C0 1AC0

// rectangles across the right edge, the bottom edge and both
2 136 064 014 005 0000FF 0 032 3D6D 13EC
2 032 0E6 006 014 123456 0 03C 0C4E 36F6
2 13B 0EC 00A 00A ABCDEF 0 014 18C4 128E

// filled circles of radius 0, 1, 5 and 20
1 0A0 078 000 000 FFFFFF 0 004 0280 01E0
1 028 028 001 000 808080 0 010 0280 0280
1 0C8 03C 005 000 00FFFF 0 094 73A0 22B0
1 0A0 078 014 000 FF00FF 0 620 3D400 2DF00

// no shape, done without writes
0 000 000 000 000 000000 0 000 0000 0000

// second strobe while busy is ignored
2 01E 01E 005 005 445566 1 019 0320 0320
1 064 0C8 005 000 0F0F0F 1 094 39D0 73A0

// zero width, then a single pixel in the last corner
2 00A 00A 000 005 0000FF 0 000 0000 0000
2 13F 0EF 001 001 010203 0 001 013F 00EF

// ==== sources.f ====
+incdir+.
gpuPixelPkg.sv
gpuCmdPkg.sv
riseEdgeDetect.sv
filledCircle.sv
filledRect.sv
gpuCmdDispatch.sv
pixelClip.sv
gpuTop.sv
tb_gpuTop.sv
